//--- design/rv_exec_pkg.sv
`default_nettype none

package rv_exec_pkg;

    localparam int XLEN      = 32;
    localparam int DIV_STEPS = 32;  // One quotient bit per step

    // Major opcodes, instruction bits 6:0
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

    localparam logic [6:0] MULDIV_FUNCT7 = 7'b0000001;  // M extension
    localparam logic [6:0] ALT_FUNCT7    = 7'b0100000;  // SUB, SRA, SRAI

    typedef enum logic [5:0] {
        OP_NONE,
        // Register-register
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        // Multiply and divide
        OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
        OP_DIV, OP_DIVU, OP_REM, OP_REMU,
        // Immediate
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
        OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        // Branch
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        // Jumps and upper immediates
        OP_JAL, OP_JALR, OP_LUI, OP_AUIPC
    } op_e;

endpackage

`default_nettype wire

//--- design/op_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module op_decoder
    import rv_exec_pkg::*;
(
    input  wire logic [XLEN-1:0] i_ir,
    output op_e                  o_op
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = i_ir[6:0];
    assign funct3 = i_ir[14:12];
    assign funct7 = i_ir[31:25];

    always_comb begin
        o_op = OP_NONE;  // Anything not matched below
        case (opcode)
            OPC_OP: begin
                if (funct7 == MULDIV_FUNCT7) begin
                    case (funct3)
                        3'd0: o_op = OP_MUL;
                        3'd1: o_op = OP_MULH;
                        3'd2: o_op = OP_MULHSU;
                        3'd3: o_op = OP_MULHU;
                        3'd4: o_op = OP_DIV;
                        3'd5: o_op = OP_DIVU;
                        3'd6: o_op = OP_REM;
                        3'd7: o_op = OP_REMU;
                    endcase
                end else if (funct7 == ALT_FUNCT7) begin
                    if (funct3 == 3'd0) o_op = OP_SUB;
                    if (funct3 == 3'd5) o_op = OP_SRA;
                end else if (funct7 == 7'd0) begin
                    case (funct3)
                        3'd0: o_op = OP_ADD;
                        3'd1: o_op = OP_SLL;
                        3'd2: o_op = OP_SLT;
                        3'd3: o_op = OP_SLTU;
                        3'd4: o_op = OP_XOR;
                        3'd5: o_op = OP_SRL;
                        3'd6: o_op = OP_OR;
                        3'd7: o_op = OP_AND;
                    endcase
                end
            end
            OPC_OP_IMM: begin
                case (funct3)
                    3'd0: o_op = OP_ADDI;
                    3'd1: if (funct7 == 7'd0) o_op = OP_SLLI;
                    3'd2: o_op = OP_SLTI;
                    3'd3: o_op = OP_SLTIU;
                    3'd4: o_op = OP_XORI;
                    3'd5: begin
                        if (funct7 == ALT_FUNCT7) o_op = OP_SRAI;
                        if (funct7 == 7'd0)       o_op = OP_SRLI;
                    end
                    3'd6: o_op = OP_ORI;
                    3'd7: o_op = OP_ANDI;
                endcase
            end
            OPC_BRANCH: begin
                case (funct3)
                    3'd0: o_op = OP_BEQ;
                    3'd1: o_op = OP_BNE;
                    3'd4: o_op = OP_BLT;
                    3'd5: o_op = OP_BGE;
                    3'd6: o_op = OP_BLTU;
                    3'd7: o_op = OP_BGEU;
                    default: o_op = OP_NONE;  // 2 and 3 are reserved
                endcase
            end
            OPC_JAL:              o_op = OP_JAL;
            OPC_JALR:             o_op = (funct3 == 3'd0) ? OP_JALR : OP_NONE;
            OPC_LUI:              o_op = OP_LUI;
            OPC_AUIPC:            o_op = OP_AUIPC;
            OPC_LOAD, OPC_STORE:  o_op = OP_NONE;  // Memory stage owns these
            default:              o_op = OP_NONE;
        endcase
    end

endmodule

`default_nettype wire

//--- design/seq_divider.sv
`timescale 1ns/1ps
`default_nettype none

module seq_divider
    import rv_exec_pkg::*;
(
    input  wire logic            i_clk,
    input  wire logic            i_arst_n,
    input  wire logic            i_start,
    input  wire logic            i_signed,
    input  wire logic            i_rem,
    input  wire logic [XLEN-1:0] i_dividend,
    input  wire logic [XLEN-1:0] i_divisor,
    output logic                 o_busy,
    output logic                 o_done,
    output logic [XLEN-1:0]      o_value
);

    logic [XLEN-1:0]              rem_q;
    logic [XLEN-1:0]              quo_q;  // Dividend shifts out, quotient shifts in
    logic [XLEN-1:0]              dvs_q;
    logic                         neg_quo_q;
    logic                         neg_rem_q;
    logic                         sel_rem_q;
    logic [$clog2(DIV_STEPS)-1:0] step_q;
    logic [XLEN-1:0]              dvd_mag;
    logic [XLEN-1:0]              dvs_mag;
    logic [XLEN:0]                trial;

    assign dvd_mag = (i_signed && i_dividend[XLEN-1]) ? -i_dividend : i_dividend;
    assign dvs_mag = (i_signed && i_divisor[XLEN-1]) ? -i_divisor : i_divisor;
    assign trial   = {rem_q, quo_q[XLEN-1]} - {1'b0, dvs_q};  // Top bit set means borrow

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_busy <= 1'b0;
            o_done <= 1'b0;
            step_q <= '0;
        end else begin
            o_done <= 1'b0;
            if (i_start) begin
                o_busy <= 1'b1;
                step_q <= '0;
            end else if (o_busy) begin
                step_q <= step_q + 1'b1;
                if (int'(step_q) == DIV_STEPS - 1) begin
                    o_busy <= 1'b0;
                    o_done <= 1'b1;  // Value is ready for one cycle
                end
            end
        end
    end

    // A zero divisor makes every step succeed, so the quotient magnitude is all ones
    // and the remainder is the dividend. Only the quotient sign must be held back.
    // MIN / -1 needs nothing extra since 2^31 as a magnitude is the dividend itself
    always_ff @(posedge i_clk) begin
        if (i_start) begin
            rem_q     <= '0;
            quo_q     <= dvd_mag;
            dvs_q     <= dvs_mag;
            neg_quo_q <= i_signed && (i_dividend[XLEN-1] ^ i_divisor[XLEN-1])
                         && (i_divisor != '0);
            neg_rem_q <= i_signed && i_dividend[XLEN-1];  // Remainder follows dividend
            sel_rem_q <= i_rem;
        end else if (o_busy) begin
            if (!trial[XLEN]) begin
                rem_q <= trial[XLEN-1:0];
                quo_q <= {quo_q[XLEN-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[XLEN-2:0], quo_q[XLEN-1]};  // Restore
                quo_q <= {quo_q[XLEN-2:0], 1'b0};
            end
        end
    end

    assign o_value = sel_rem_q ? (neg_rem_q ? -rem_q : rem_q)
                               : (neg_quo_q ? -quo_q : quo_q);

endmodule

`default_nettype wire

//--- design/exec_unit.sv
`timescale 1ns/1ps
`default_nettype none

module exec_unit
    import rv_exec_pkg::*;
(
    input  wire logic            i_clk,
    input  wire logic            i_arst_n,
    input  wire logic            i_valid,
    input  wire op_e             i_op,
    input  wire logic [XLEN-1:0] i_ir,
    input  wire logic [XLEN-1:0] i_rs1,
    input  wire logic [XLEN-1:0] i_rs2,
    input  wire logic [XLEN-1:0] i_pc,
    output logic [XLEN-1:0]      o_result,
    output logic                 o_load_regfile,
    output logic [XLEN-1:0]      o_jump_address,
    output logic                 o_jump,
    output logic                 o_busy
);

    logic [XLEN-1:0]          imm_i;
    logic [XLEN-1:0]          imm_b;
    logic [XLEN-1:0]          imm_j;
    logic [XLEN-1:0]          imm_u;
    logic                     rs_eq;
    logic                     rs_lt;
    logic                     rs_ltu;
    logic                     mul_a_signed;
    logic                     mul_b_signed;
    logic signed [XLEN:0]     mul_a;
    logic signed [XLEN:0]     mul_b;
    logic signed [2*XLEN+1:0] mul_prod;
    logic [XLEN-1:0]          alu_res;
    logic                     alu_wr;
    logic                     taken;
    logic [XLEN-1:0]          jump_tgt;
    logic                     is_div;
    logic                     div_busy;
    logic                     div_done;
    logic [XLEN-1:0]          div_value;

    assign imm_i = {{20{i_ir[31]}}, i_ir[31:20]};
    assign imm_b = {{19{i_ir[31]}}, i_ir[31], i_ir[7], i_ir[30:25], i_ir[11:8], 1'b0};
    assign imm_j = {{11{i_ir[31]}}, i_ir[31], i_ir[19:12], i_ir[20], i_ir[30:21], 1'b0};
    assign imm_u = {i_ir[31:12], 12'd0};

    assign rs_eq  = (i_rs1 == i_rs2);
    assign rs_lt  = ($signed(i_rs1) < $signed(i_rs2));
    assign rs_ltu = (i_rs1 < i_rs2);

    // One 33x33 signed multiplier, extension bit picks signed or unsigned per operand
    assign mul_a_signed = (i_op == OP_MULH) || (i_op == OP_MULHSU);
    assign mul_b_signed = (i_op == OP_MULH);
    assign mul_a        = {mul_a_signed & i_rs1[XLEN-1], i_rs1};
    assign mul_b        = {mul_b_signed & i_rs2[XLEN-1], i_rs2};
    assign mul_prod     = mul_a * mul_b;

    always_comb begin
        alu_res = '0;
        alu_wr  = 1'b1;
        case (i_op)
            OP_ADD:    alu_res = i_rs1 + i_rs2;
            OP_SUB:    alu_res = i_rs1 - i_rs2;
            OP_SLL:    alu_res = i_rs1 << i_rs2[4:0];
            OP_SLT:    alu_res = {{(XLEN-1){1'b0}}, rs_lt};
            OP_SLTU:   alu_res = {{(XLEN-1){1'b0}}, rs_ltu};
            OP_XOR:    alu_res = i_rs1 ^ i_rs2;
            OP_SRL:    alu_res = i_rs1 >> i_rs2[4:0];
            OP_SRA:    alu_res = $signed(i_rs1) >>> i_rs2[4:0];
            OP_OR:     alu_res = i_rs1 | i_rs2;
            OP_AND:    alu_res = i_rs1 & i_rs2;
            OP_MUL:    alu_res = mul_prod[XLEN-1:0];
            OP_MULH, OP_MULHSU, OP_MULHU:
                       alu_res = mul_prod[2*XLEN-1:XLEN];
            OP_ADDI:   alu_res = i_rs1 + imm_i;
            OP_SLTI:   alu_res = {{(XLEN-1){1'b0}}, $signed(i_rs1) < $signed(imm_i)};
            OP_SLTIU:  alu_res = {{(XLEN-1){1'b0}}, i_rs1 < imm_i};
            OP_XORI:   alu_res = i_rs1 ^ imm_i;
            OP_ORI:    alu_res = i_rs1 | imm_i;
            OP_ANDI:   alu_res = i_rs1 & imm_i;
            OP_SLLI:   alu_res = i_rs1 << imm_i[4:0];
            OP_SRLI:   alu_res = i_rs1 >> imm_i[4:0];
            OP_SRAI:   alu_res = $signed(i_rs1) >>> imm_i[4:0];
            OP_JAL, OP_JALR:
                       alu_res = i_pc + XLEN'(4);  // Link value
            OP_LUI:    alu_res = imm_u;
            OP_AUIPC:  alu_res = i_pc + imm_u;
            default:   alu_wr  = 1'b0;  // Branches, divides, OP_NONE
        endcase
    end

    always_comb begin
        jump_tgt = i_pc + imm_b;
        case (i_op)
            OP_BEQ:   taken = rs_eq;
            OP_BNE:   taken = !rs_eq;
            OP_BLT:   taken = rs_lt;
            OP_BGE:   taken = !rs_lt;
            OP_BLTU:  taken = rs_ltu;
            OP_BGEU:  taken = !rs_ltu;
            OP_JAL: begin
                taken    = 1'b1;
                jump_tgt = i_pc + imm_j;
            end
            OP_JALR: begin
                taken    = 1'b1;
                jump_tgt = (i_rs1 + imm_i) & ~XLEN'(1);  // Bit 0 cleared
            end
            default:  taken = 1'b0;
        endcase
    end

    assign is_div = (i_op == OP_DIV) || (i_op == OP_DIVU) || (i_op == OP_REM) || (i_op == OP_REMU);

    seq_divider seq_divider_inst (
        .i_clk      (i_clk),
        .i_arst_n   (i_arst_n),
        .i_start    (i_valid && is_div),
        .i_signed   ((i_op == OP_DIV) || (i_op == OP_REM)),
        .i_rem      ((i_op == OP_REM) || (i_op == OP_REMU)),
        .i_dividend (i_rs1),
        .i_divisor  (i_rs2),
        .o_busy     (div_busy),
        .o_done     (div_done),
        .o_value    (div_value)
    );

    assign o_busy = div_busy || div_done;  // Drops on the edge that writes the result

    always_ff @(posedge i_clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_result       <= '0;
            o_load_regfile <= 1'b0;
            o_jump_address <= '0;
            o_jump         <= 1'b0;
        end else begin
            o_load_regfile <= 1'b0;
            o_jump         <= 1'b0;
            if (i_valid && alu_wr) begin
                o_result       <= alu_res;
                o_load_regfile <= 1'b1;
            end else if (div_done) begin
                o_result       <= div_value;
                o_load_regfile <= 1'b1;
            end
            if (i_valid && taken) begin
                o_jump_address <= jump_tgt;
                o_jump         <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module exec_top
    import rv_exec_pkg::*;
(
    input  wire logic            i_clk,
    input  wire logic            i_arst_n,
    input  wire logic            i_valid,
    input  wire logic [XLEN-1:0] i_ir,
    input  wire logic [XLEN-1:0] i_rs1,
    input  wire logic [XLEN-1:0] i_rs2,
    input  wire logic [XLEN-1:0] i_pc,
    output logic [XLEN-1:0]      o_result,
    output logic                 o_load_regfile,
    output logic [XLEN-1:0]      o_jump_address,
    output logic                 o_jump,
    output logic                 o_busy
);

    op_e dec_op;

    op_decoder op_decoder_inst (
        .i_ir (i_ir),
        .o_op (dec_op)
    );

    exec_unit exec_unit_inst (
        .i_clk          (i_clk),
        .i_arst_n       (i_arst_n),
        .i_valid        (i_valid),
        .i_op           (dec_op),
        .i_ir           (i_ir),
        .i_rs1          (i_rs1),
        .i_rs2          (i_rs2),
        .i_pc           (i_pc),
        .o_result       (o_result),
        .o_load_regfile (o_load_regfile),
        .o_jump_address (o_jump_address),
        .o_jump         (o_jump),
        .o_busy         (o_busy)
    );

endmodule

`default_nettype wire

//--- test/exec_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module exec_assertions (
    input wire logic i_clk,
    input wire logic i_arst_n,
    input wire logic i_valid,
    input wire logic o_load_regfile,
    input wire logic o_jump,
    input wire logic o_busy
);

    // No issue while a division runs
    assert property (@(posedge i_clk) disable iff (!i_arst_n) o_busy |-> !i_valid)
        else $error("issue while busy");

    assert property (@(posedge i_clk) disable iff (!i_arst_n) o_jump |-> $past(i_valid))
        else $error("jump pulse without an issue");

    // Divide results land as busy falls
    assert property (@(posedge i_clk) disable iff (!i_arst_n)
                     o_load_regfile |-> $past(i_valid) || $past(o_busy))
        else $error("write pulse without a cause");

    assert property (@(posedge i_clk) !i_arst_n |-> !o_jump && !o_load_regfile && !o_busy)
        else $error("control output high in reset");

endmodule

bind exec_top exec_assertions exec_assertions_inst (.*);

`default_nettype wire

//--- test/tb_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_exec_top;
    import rv_exec_pkg::*;

    localparam int CLK_NS  = 40;
    localparam int N_TESTS = 6;
    localparam int ISSUES  = 40;  // Upper bound on issues in any one test

    logic i_clk, i_arst_n, i_valid;
    logic [XLEN-1:0] i_ir, i_rs1, i_rs2, i_pc;
    logic [XLEN-1:0] o_result, o_jump_address;
    logic o_load_regfile, o_jump, o_busy;
    int errors = 0;
    int failed_tests = 0;
    logic [31:0] lfsr_state = 32'h2a3b_241a;
    op_e rr_ops [8] = '{OP_ADD, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_OR, OP_AND};
    op_e im_ops [8] = '{OP_ADDI, OP_SLLI, OP_SLTI, OP_SLTIU, OP_XORI, OP_SRLI, OP_ORI, OP_ANDI};
    op_e br_ops [8] = '{OP_BEQ, OP_BNE, OP_NONE, OP_NONE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    op_e md_ops [8] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU, OP_DIV, OP_DIVU, OP_REM, OP_REMU};

    exec_top exec_top_inst (.*);

    initial begin
        i_clk = 1'b0;
        forever #(CLK_NS / 2) i_clk = ~i_clk;
    end

    initial begin
        #(N_TESTS * ISSUES * (DIV_STEPS + 4) * CLK_NS);
        $display("Watchdog expired, a test never finished");
        $display("=== FAIL ===");
        $finish;
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // Taps 32 22 2 1
    endfunction

    task automatic rand32(output logic [31:0] v);
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // Encoders, rd = x1, rs1 = x2, rs2 = x3
    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd3, 5'd2, f3, 5'd1, OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                          input logic [6:0] opc);
        return {imm, 5'd2, f3, 5'd1, opc};
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] off, input logic [2:0] f3);
        return {off[12], off[10:5], 5'd3, 5'd2, f3, off[4:1], off[11], OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_j(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd1, OPC_JAL};
    endfunction

    // Reference model of the RV32I integer ops, b is rs2 or the immediate
    function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'd0, $signed(a) < $signed(b)};
            3'd3: return {31'd0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] ref_mul(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        logic signed [65:0] sa;
        logic signed [65:0] sb;
        logic signed [65:0] p;
        sa = (f3 == 3'd1 || f3 == 3'd2) ? 66'($signed(a)) : {34'd0, a};
        sb = (f3 == 3'd1) ? 66'($signed(b)) : {34'd0, b};
        p  = sa * sb;
        return (f3 == 3'd0) ? p[31:0] : p[63:32];
    endfunction

    function automatic logic [31:0] ref_div(input logic [2:0] f3, input logic [31:0] a,
                                            input logic [31:0] b);
        logic sgn;
        logic [31:0] q;
        logic [31:0] r;
        sgn = !f3[0];
        if (b == 0) begin
            q = '1;
            r = a;
        end else if (sgn && a == 32'h8000_0000 && b == '1) begin
            q = a;
            r = 0;
        end else if (sgn) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);
        end else begin
            q = a / b;
            r = a % b;
        end
        return f3[1] ? r : q;
    endfunction

    function automatic logic ref_branch(input logic [2:0] f3, input logic [31:0] a,
                                        input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_result(input string name, input logic [XLEN-1:0] exp,
                                input logic [XLEN-1:0] act);
        if (exp !== act) begin
            $display("error: %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_jump(input string name, input logic exp_taken,
                              input logic [XLEN-1:0] exp_addr, input logic act_taken,
                              input logic [XLEN-1:0] act_addr);
        if (exp_taken !== act_taken || (exp_taken && exp_addr !== act_addr)) begin
            $display("error: %s expected jump %b %h actual jump %b %h",
                     name, exp_taken, exp_addr, act_taken, act_addr);
            errors++;
        end
    endtask

    task automatic check_op(input string name, input op_e exp, input op_e act);
        if (exp !== act) begin
            $display("error: %s expected %s actual %s", name, exp.name(), act.name());
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            $display("error: %s expected %b actual %b", name, exp, act);
            errors++;
        end
    endtask

    task automatic issue(input logic [31:0] ir, a, b, pc);
        @(negedge i_clk);
        i_valid = 1'b1;
        i_ir    = ir;
        i_rs1   = a;
        i_rs2   = b;
        i_pc    = pc;
    endtask

    task automatic run_single(input string name, input logic [31:0] ir, a, b, pc,
                              input op_e exp_op, input logic exp_wr,
                              input logic [31:0] exp_res, input logic exp_jmp,
                              input logic [31:0] exp_addr);
        issue(ir, a, b, pc);
        #1 check_op(name, exp_op, exec_top_inst.dec_op);
        @(negedge i_clk);
        i_valid = 1'b0;
        check_bit({name, " write"}, exp_wr, o_load_regfile);
        if (exp_wr)
            check_result(name, exp_res, o_result);
        check_jump(name, exp_jmp, exp_addr, o_jump, o_jump_address);
    endtask

    task automatic run_div(input string name, input logic [2:0] f3, input logic [31:0] a, b);
        int edges;
        issue(enc_r(MULDIV_FUNCT7, f3), a, b, 0);
        #1 check_op(name, md_ops[f3], exec_top_inst.dec_op);
        @(negedge i_clk);
        i_valid = 1'b0;
        edges   = 0;
        while (!o_load_regfile && edges < DIV_STEPS + 8) begin
            if (!o_busy) begin
                $display("error: %s busy went low before the result", name);
                errors++;
            end
            @(negedge i_clk);
            edges++;
        end
        if (!o_load_regfile) begin
            $display("error: %s the divider never wrote a result", name);
            errors++;
        end else begin
            check_result({name, " latency"}, DIV_STEPS + 1, edges);
            check_result(name, ref_div(f3, a, b), o_result);
            check_bit({name, " busy"}, 1'b0, o_busy);
        end
    endtask

    task automatic report(input string name, input int e0);
        $display("%-10s %s", name, (errors == e0) ? "passed" : "failed");
        if (errors != e0)
            failed_tests++;
    endtask

    task automatic test_reg_reg();
        int e0;
        logic [31:0] a [4];
        logic [31:0] b [4];
        e0 = errors;
        a[0] = 32'h8000_0000;
        b[0] = 32'hffff_ffff;
        a[1] = 32'h7fff_ffff;
        b[1] = 32'h0000_001f;
        rand32(a[2]);
        rand32(b[2]);
        rand32(a[3]);
        rand32(b[3]);
        for (int k = 0; k < 4; k++) begin
            for (int f = 0; f < 8; f++)
                run_single($sformatf("rr f3=%0d", f), enc_r(7'd0, f), a[k], b[k], 0,
                           rr_ops[f], 1, ref_alu(f, 0, a[k], b[k]), 0, 0);
            run_single("sub", enc_r(ALT_FUNCT7, 0), a[k], b[k], 0, OP_SUB, 1,
                       ref_alu(0, 1, a[k], b[k]), 0, 0);
            run_single("sra", enc_r(ALT_FUNCT7, 5), a[k], b[k], 0, OP_SRA, 1,
                       ref_alu(5, 1, a[k], b[k]), 0, 0);
        end
        report("reg_reg", e0);
    endtask

    task automatic test_imm();
        int e0;
        logic [11:0] imm;
        logic [31:0] a;
        e0 = errors;
        a  = 32'h8000_00f0;
        for (int f = 0; f < 8; f++) begin
            imm = (f == 1 || f == 5) ? 12'd7 : 12'hffb;  // Shift amount or -5
            run_single($sformatf("imm f3=%0d", f), enc_i(imm, f, OPC_OP_IMM), a, 0, 0,
                       im_ops[f], 1, ref_alu(f, 0, a, {{20{imm[11]}}, imm}), 0, 0);
        end
        run_single("srai", enc_i(12'h407, 5, OPC_OP_IMM), a, 0, 0, OP_SRAI, 1,
                   ref_alu(5, 1, a, 7), 0, 0);
        run_single("lui", {20'hfedcb, 5'd1, OPC_LUI}, 0, 0, 0, OP_LUI, 1,
                   32'hfedc_b000, 0, 0);
        run_single("auipc", {20'h80001, 5'd1, OPC_AUIPC}, 0, 0, 32'h0000_1004, OP_AUIPC, 1,
                   32'h8000_2004, 0, 0);
        report("imm", e0);
    endtask

    task automatic test_mul();
        int e0;
        logic [31:0] a;
        logic [31:0] b;
        e0 = errors;
        for (int k = 0; k < 4; k++) begin
            rand32(a);
            rand32(b);
            if (k == 0) a = 32'h8000_0000;
            if (k == 0) b = 32'h8000_0000;
            if (k == 1) b = 32'hffff_ffff;
            for (int f = 0; f < 4; f++)
                run_single($sformatf("mul f3=%0d", f), enc_r(MULDIV_FUNCT7, f), a, b, 0,
                           md_ops[f], 1, ref_mul(f, a, b), 0, 0);
        end
        report("mul", e0);
    endtask

    task automatic test_div();
        int e0;
        logic [31:0] a;
        logic [31:0] b;
        e0 = errors;
        rand32(a);
        rand32(b);
        for (int f = 4; f < 8; f++) begin
            run_div($sformatf("div f3=%0d rand", f), f, a, b);
            run_div($sformatf("div f3=%0d neg", f), f, 32'hffff_ff9c, 32'd7);
            run_div($sformatf("div f3=%0d zero", f), f, a, 0);
            run_div($sformatf("div f3=%0d ovf", f), f, 32'h8000_0000, 32'hffff_ffff);
        end
        report("div", e0);
    endtask

    task automatic test_branch();
        int e0;
        logic [31:0] a [3] = '{32'd5, 32'hffff_ffff, 32'd1};
        logic [31:0] b [3] = '{32'd5, 32'd1, 32'hffff_ffff};
        logic t;
        e0 = errors;
        for (int f = 0; f < 8; f++) begin
            if (f == 2 || f == 3)
                continue;
            for (int k = 0; k < 3; k++) begin
                t = ref_branch(f, a[k], b[k]);
                run_single($sformatf("br f3=%0d", f), enc_b(-13'sd16, f), a[k], b[k],
                           32'h1000, br_ops[f], 0, 0, t, 32'h0ff0);
            end
        end
        run_single("jal", enc_j(21'h800), 0, 0, 32'h2000, OP_JAL, 1, 32'h2004,
                   1, 32'h2800);
        run_single("jalr", enc_i(12'hffd, 0, OPC_JALR), 32'h3000, 0, 32'h2000, OP_JALR, 1,
                   32'h2004, 1, 32'h2ffc);
        report("branch", e0);
    endtask

    task automatic test_mem();
        int e0;
        e0 = errors;
        run_single("load", enc_i(12'd4, 2, OPC_LOAD), 1, 2, 0, OP_NONE, 0, 0, 0, 0);
        run_single("store", {7'd0, 5'd3, 5'd2, 3'd2, 5'd4, OPC_STORE}, 1, 2, 0, OP_NONE,
                   0, 0, 0, 0);
        repeat (4) begin
            @(negedge i_clk);
            if (o_load_regfile || o_jump) begin
                $display("error: mem a pulse appeared after a load or store");
                errors++;
            end
        end
        issue(enc_r(7'd0, 0), 32'd10, 32'd20, 0);
        issue(enc_r(7'd0, 4), 32'hf0f0, 32'h0ff0, 0);
        check_bit("b2b first write", 1, o_load_regfile);
        check_result("b2b add", 32'd30, o_result);
        @(negedge i_clk);
        i_valid = 1'b0;
        check_bit("b2b second write", 1, o_load_regfile);
        check_result("b2b xor", 32'hff00, o_result);
        report("mem", e0);
    endtask

    initial begin
        i_arst_n = 1'b0;
        i_valid  = 1'b0;
        i_ir     = '0;
        i_rs1    = '0;
        i_rs2    = '0;
        i_pc     = '0;
        repeat (4) @(posedge i_clk);
        @(negedge i_clk);
        i_arst_n = 1'b1;
        test_reg_reg();
        test_imm();
        test_mul();
        test_div();
        test_branch();
        test_mem();
        $display("tests %0d, failed %0d, errors %0d", N_TESTS, failed_tests, errors);
        if (errors == 0)
            $display("=== PASS ===");
        else
            $display("=== FAIL ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
design/rv_exec_pkg.sv
design/op_decoder.sv
design/seq_divider.sv
design/exec_unit.sv
design/exec_top.sv
test/exec_assertions.sv
test/tb_exec_top.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= tb_exec_top
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf $(OBJ_DIR)
